//--- build.f
design/cpuPkg.sv
design/mainDecoder.sv
design/regFile.sv
design/stageReg.sv
design/executeUnit.sv
design/hazardUnit.sv
design/datapath.sv
sim/wbChecker.sv
sim/tbDatapath.sv

//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing -j 0
TOP      = tbDatapath
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- sim/tbDatapath.sv
module tbDatapath;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClkPeriod     = 20;
    localparam int DriveDelay    = 2;
    localparam int ResetCycles   = 4;
    localparam int NumTests      = 5;
    localparam int MaxProg       = 12;
    localparam int MaxWrites     = 10;
    localparam int DrainCycles   = 20;
    localparam int MemWords      = 64;
    localparam int TimeoutCycles = NumTests * (MaxProg + DrainCycles + ResetCycles) + 50;

    logic                            clk;
    logic                            rst;
    logic [cpuPkg::DataWidth-1:0]    instr;
    logic [cpuPkg::DataWidth-1:0]    memRdata;
    logic [cpuPkg::DataWidth-1:0]    instAddr;
    logic                            instEn;
    logic                            memEn;
    logic [cpuPkg::DataWidth-1:0]    memAddr;
    logic [3:0]                      memWen;
    logic [cpuPkg::DataWidth-1:0]    memWdata;
    logic [cpuPkg::DataWidth-1:0]    wbPc;
    logic [3:0]                      wbRfWen;
    logic [cpuPkg::RegAddrWidth-1:0] wbRfWnum;
    logic [cpuPkg::DataWidth-1:0]    wbRfWdata;

    logic [cpuPkg::DataWidth-1:0]    imem [MemWords];
    logic [cpuPkg::DataWidth-1:0]    dmem [MemWords];

    // stimulus table
    logic [cpuPkg::DataWidth-1:0]    progTab [NumTests][MaxProg];
    int                              progLen [NumTests];
    logic [cpuPkg::DataWidth-1:0]    expPc   [NumTests][MaxWrites];
    logic [cpuPkg::RegAddrWidth-1:0] expNum  [NumTests][MaxWrites];
    logic [cpuPkg::DataWidth-1:0]    expData [NumTests][MaxWrites];
    int                              expLen  [NumTests];

    // expected writes of the running test
    logic [cpuPkg::DataWidth-1:0]    curExpPc   [MaxWrites];
    logic [cpuPkg::RegAddrWidth-1:0] curExpNum  [MaxWrites];
    logic [cpuPkg::DataWidth-1:0]    curExpData [MaxWrites];
    int                              curExpLen;
    int                              testIdx;
    logic                            testDone;
    logic                            runDone;
    int                              errCount;
    int                              cycleCount;

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    datapath u_datapath (
        .clk              (clk),
        .rst_i            (rst),
        .instr_i          (instr),
        .memRdata_i       (memRdata),
        .instAddr_o       (instAddr),
        .instEn_o         (instEn),
        .memEn_o          (memEn),
        .memAddr_o        (memAddr),
        .memWen_o         (memWen),
        .memWdata_o       (memWdata),
        .debugWbPc_o      (wbPc),
        .debugWbRfWen_o   (wbRfWen),
        .debugWbRfWnum_o  (wbRfWnum),
        .debugWbRfWdata_o (wbRfWdata)
    );

    wbChecker #(.MaxWrites(MaxWrites)) u_wbChecker (
        .clk              (clk),
        .rst_i            (rst),
        .instAddr_i       (instAddr),
        .instEn_i         (instEn),
        .memEn_i          (memEn),
        .memWen_i         (memWen),
        .debugWbPc_i      (wbPc),
        .debugWbRfWen_i   (wbRfWen),
        .debugWbRfWnum_i  (wbRfWnum),
        .debugWbRfWdata_i (wbRfWdata),
        .testId_i         (testIdx),
        .testDone_i       (testDone),
        .runDone_i        (runDone),
        .expPc_i          (curExpPc),
        .expNum_i         (curExpNum),
        .expData_i        (curExpData),
        .expLen_i         (curExpLen),
        .errCount_o       (errCount)
    );

    // both memories answer in the same cycle
    assign instr    = (instEn === 1'b1) ? imem[instAddr[7:2]] : 32'h0;
    assign memRdata = (memEn === 1'b1) ? dmem[memAddr[7:2]] : 32'h0;

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MemWords; i++) begin
                dmem[i] <= 32'h0; // fresh data memory per test
            end
        end else if (memEn && memWen == 4'hf) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
    end

    function automatic logic [31:0] encodeR(input logic [5:0] fn, input int rd, input int rs,
                                            input int rt);
        return {cpuPkg::OpRtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input int rt, input int rs,
                                            input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    task automatic addInstr(input int t, input logic [31:0] word);
        progTab[t][progLen[t]] = word;
        progLen[t]++;
    endtask

    // idx is the program slot of the writing instruction
    task automatic addWrite(input int t, input int idx, input int num,
                            input logic [31:0] data);
        expPc[t][expLen[t]]   = cpuPkg::ResetPc + idx * 4;
        expNum[t][expLen[t]]  = num[4:0];
        expData[t][expLen[t]] = data;
        expLen[t]++;
    endtask

    task automatic buildTable();
        for (int t = 0; t < NumTests; t++) begin
            progLen[t] = 0;
            expLen[t]  = 0;
            for (int i = 0; i < MaxProg; i++) begin
                progTab[t][i] = 32'h0; // sll $0 pads as a nop
            end
        end
        // dependent ALU chain
        addInstr(0, encodeI(cpuPkg::OpAddiu, 1, 0, 16'd5));
        addInstr(0, encodeI(cpuPkg::OpAddiu, 2, 1, 16'd3));
        addInstr(0, encodeR(cpuPkg::FnAddu, 3, 2, 1));
        addInstr(0, encodeR(cpuPkg::FnSubu, 4, 3, 1));
        addInstr(0, encodeR(cpuPkg::FnAnd, 5, 4, 3));
        addInstr(0, encodeR(cpuPkg::FnOr, 6, 5, 1));
        addInstr(0, encodeR(cpuPkg::FnSlt, 7, 1, 6));
        addInstr(0, encodeR(cpuPkg::FnSlt, 8, 6, 1));
        addInstr(0, encodeI(cpuPkg::OpAddiu, 9, 0, 16'hffff));
        addInstr(0, encodeR(cpuPkg::FnSlt, 10, 9, 1)); // signed compare
        addWrite(0, 0, 1, 32'h5);
        addWrite(0, 1, 2, 32'h8);
        addWrite(0, 2, 3, 32'hd);
        addWrite(0, 3, 4, 32'h8);
        addWrite(0, 4, 5, 32'h8);
        addWrite(0, 5, 6, 32'hd);
        addWrite(0, 6, 7, 32'h1);
        addWrite(0, 7, 8, 32'h0);
        addWrite(0, 8, 9, 32'hffff_ffff);
        addWrite(0, 9, 10, 32'h1);
        // constants and $zero
        addInstr(1, encodeI(cpuPkg::OpLui, 1, 0, 16'h1234));
        addInstr(1, encodeI(cpuPkg::OpOri, 1, 1, 16'h5678));
        addInstr(1, encodeI(cpuPkg::OpAddiu, 0, 0, 16'd7)); // dropped write
        addInstr(1, encodeR(cpuPkg::FnAddu, 3, 0, 1));
        addInstr(1, encodeI(cpuPkg::OpOri, 2, 0, 16'hffff));
        addInstr(1, encodeI(cpuPkg::OpLui, 4, 0, 16'hffff));
        addInstr(1, encodeI(cpuPkg::OpOri, 4, 4, 16'h8001));
        addWrite(1, 0, 1, 32'h1234_0000);
        addWrite(1, 1, 1, 32'h1234_5678);
        addWrite(1, 3, 3, 32'h1234_5678);
        addWrite(1, 4, 2, 32'h0000_ffff);
        addWrite(1, 5, 4, 32'hffff_0000);
        addWrite(1, 6, 4, 32'hffff_8001);
        // store, load and load-use
        addInstr(2, encodeI(cpuPkg::OpAddiu, 1, 0, 16'h2a));
        addInstr(2, encodeI(cpuPkg::OpAddiu, 2, 0, 16'd8));
        addInstr(2, encodeI(cpuPkg::OpSw, 1, 2, 16'd4));
        addInstr(2, encodeI(cpuPkg::OpLw, 3, 2, 16'd4));
        addInstr(2, encodeR(cpuPkg::FnAddu, 4, 3, 1));
        addInstr(2, encodeI(cpuPkg::OpSw, 4, 0, 16'd0));
        addInstr(2, encodeI(cpuPkg::OpLw, 5, 0, 16'd0));
        addInstr(2, encodeR(cpuPkg::FnAddu, 6, 5, 5));
        addWrite(2, 0, 1, 32'h2a);
        addWrite(2, 1, 2, 32'h8);
        addWrite(2, 3, 3, 32'h2a);
        addWrite(2, 4, 4, 32'h54);
        addWrite(2, 6, 5, 32'h54);
        addWrite(2, 7, 6, 32'ha8);
        // branches
        addInstr(3, encodeI(cpuPkg::OpAddiu, 1, 0, 16'd3));
        addInstr(3, encodeI(cpuPkg::OpAddiu, 2, 0, 16'd3));
        addInstr(3, encodeI(cpuPkg::OpBeq, 2, 1, 16'd2)); // taken
        addInstr(3, encodeI(cpuPkg::OpAddiu, 3, 0, 16'h11));
        addInstr(3, encodeI(cpuPkg::OpAddiu, 4, 0, 16'h22));
        addInstr(3, encodeI(cpuPkg::OpAddiu, 5, 0, 16'h33));
        addInstr(3, encodeI(cpuPkg::OpBne, 2, 1, 16'd1)); // falls through
        addInstr(3, encodeI(cpuPkg::OpAddiu, 6, 0, 16'h44));
        addInstr(3, encodeI(cpuPkg::OpBne, 1, 5, 16'd1));
        addInstr(3, encodeI(cpuPkg::OpAddiu, 7, 0, 16'h55));
        addInstr(3, encodeI(cpuPkg::OpAddiu, 8, 0, 16'h66));
        addWrite(3, 0, 1, 32'h3);
        addWrite(3, 1, 2, 32'h3);
        addWrite(3, 5, 5, 32'h33);
        addWrite(3, 7, 6, 32'h44);
        addWrite(3, 10, 8, 32'h66);
        // unknown encodings
        addInstr(4, encodeI(cpuPkg::OpAddiu, 1, 0, 16'h10));
        addInstr(4, 32'hfc22_0005); // opcode 0x3f
        addInstr(4, encodeI(cpuPkg::OpAddiu, 2, 1, 16'd2));
        addInstr(4, encodeR(6'h20, 3, 1, 1)); // trapping add, not kept
        addInstr(4, encodeR(cpuPkg::FnOr, 4, 2, 1));
        addInstr(4, encodeR(cpuPkg::FnAddu, 5, 3, 1));
        addWrite(4, 0, 1, 32'h10);
        addWrite(4, 2, 2, 32'h12);
        addWrite(4, 4, 4, 32'h12);
        addWrite(4, 5, 5, 32'h10);
    endtask

    task automatic loadTest(input int t);
        for (int i = 0; i < MemWords; i++) begin
            imem[i] = (i < MaxProg) ? progTab[t][i] : 32'h0;
        end
        for (int i = 0; i < MaxWrites; i++) begin
            curExpPc[i]   = expPc[t][i];
            curExpNum[i]  = expNum[t][i];
            curExpData[i] = expData[t][i];
        end
        curExpLen = expLen[t];
        testIdx   = t;
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("run stopped after %0d cycles without reaching the end of the tests",
                 cycleCount);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        testDone = 1'b0;
        runDone  = 1'b0;
        buildTable();
        for (int t = 0; t < NumTests; t++) begin
            rst = 1'b1;
            loadTest(t);
            repeat (ResetCycles) @(posedge clk);
            #DriveDelay rst = 1'b0;
            repeat (progLen[t] + DrainCycles) @(posedge clk);
            #DriveDelay testDone = 1'b1;
            @(posedge clk);
            #DriveDelay testDone = 1'b0;
        end
        runDone = 1'b1;
        @(posedge clk);
        #DriveDelay runDone = 1'b0;
        if (errCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sim/wbChecker.sv
module wbChecker #(
    parameter int MaxWrites = 10
) (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic [cpuPkg::DataWidth-1:0]    instAddr_i,
    input  logic                            instEn_i,
    input  logic                            memEn_i,
    input  logic [3:0]                      memWen_i,
    input  logic [cpuPkg::DataWidth-1:0]    debugWbPc_i,
    input  logic [3:0]                      debugWbRfWen_i,
    input  logic [cpuPkg::RegAddrWidth-1:0] debugWbRfWnum_i,
    input  logic [cpuPkg::DataWidth-1:0]    debugWbRfWdata_i,
    input  int                              testId_i,
    input  logic                            testDone_i,
    input  logic                            runDone_i,
    input  logic [cpuPkg::DataWidth-1:0]    expPc_i [MaxWrites],
    input  logic [cpuPkg::RegAddrWidth-1:0] expNum_i [MaxWrites],
    input  logic [cpuPkg::DataWidth-1:0]    expData_i [MaxWrites],
    input  int                              expLen_i,
    output int                              errCount_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int seen     = 0; // writes observed in the current test
    int testErrs = 0;
    int errTotal = 0;
    int testsRun = 0;
    int testsBad = 0;
    logic rstSeen = 1'b0; // reset was already high at the previous edge

    assign errCount_o = errTotal;

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("Error: %s is 0x%h, expected 0x%h (test %0d)", name, got, want, testId_i);
        testErrs++;
    endtask

    always @(posedge clk) begin
        rstSeen <= rst_i;
        if (rst_i && rstSeen) begin // pipeline registers cleared by now
            if (instAddr_i !== cpuPkg::ResetPc) begin
                reportMismatch("instAddr_o", instAddr_i, cpuPkg::ResetPc);
            end
            if (instEn_i !== 1'b1) begin
                reportMismatch("instEn_o", 32'(instEn_i), 32'h1);
            end
            if (memEn_i !== 1'b0) begin
                reportMismatch("memEn_o", 32'(memEn_i), 32'h0);
            end
            if (memWen_i !== 4'h0) begin
                reportMismatch("memWen_o", 32'(memWen_i), 32'h0);
            end
            if (debugWbRfWen_i !== 4'h0) begin
                reportMismatch("debugWbRfWen_o", 32'(debugWbRfWen_i), 32'h0);
            end
        end

        if (!rst_i && debugWbRfWen_i != 4'h0) begin
            if (debugWbRfWen_i != 4'hf) begin
                reportMismatch("debugWbRfWen_o", 32'(debugWbRfWen_i), 32'hf);
            end
            if (seen >= expLen_i) begin
                $display("test %0d: unexpected register write to r%0d at pc 0x%h", testId_i,
                         debugWbRfWnum_i, debugWbPc_i);
                testErrs++;
            end else begin
                if (debugWbPc_i !== expPc_i[seen]) begin
                    reportMismatch("debugWbPc_o", debugWbPc_i, expPc_i[seen]);
                end
                if (debugWbRfWnum_i !== expNum_i[seen]) begin
                    reportMismatch("debugWbRfWnum_o", 32'(debugWbRfWnum_i),
                                   32'(expNum_i[seen]));
                end
                if (debugWbRfWdata_i !== expData_i[seen]) begin
                    reportMismatch("debugWbRfWdata_o", debugWbRfWdata_i, expData_i[seen]);
                end
            end
            seen++;
        end

        if (testDone_i) begin
            if (seen < expLen_i) begin
                $display("test %0d: %0d expected register writes never happened", testId_i,
                         expLen_i - seen);
                testErrs++;
            end
            $display("test %0d: %0d writes seen, %0d expected, %0d errors", testId_i, seen,
                     expLen_i, testErrs);
            testsRun++;
            if (testErrs != 0) begin
                testsBad++;
            end
            errTotal = errTotal + testErrs;
            seen     = 0;
            testErrs = 0;
        end

        if (runDone_i) begin
            $display("%0d tests run, %0d clean, %0d with errors, %0d errors in total",
                     testsRun, testsRun - testsBad, testsBad, errTotal);
        end
    end

endmodule

//--- design/datapath.sv
module datapath (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic [cpuPkg::DataWidth-1:0]    instr_i,
    input  logic [cpuPkg::DataWidth-1:0]    memRdata_i,
    output logic [cpuPkg::DataWidth-1:0]    instAddr_o,
    output logic                            instEn_o,
    output logic                            memEn_o,
    output logic [cpuPkg::DataWidth-1:0]    memAddr_o,
    output logic [3:0]                      memWen_o,
    output logic [cpuPkg::DataWidth-1:0]    memWdata_o,
    output logic [cpuPkg::DataWidth-1:0]    debugWbPc_o,
    output logic [3:0]                      debugWbRfWen_o,
    output logic [cpuPkg::RegAddrWidth-1:0] debugWbRfWnum_o,
    output logic [cpuPkg::DataWidth-1:0]    debugWbRfWdata_o
);

    logic [cpuPkg::DataWidth-1:0]    pc;
    logic                            pcAligned;
    cpuPkg::fdPayloadT               fdIn, fdQ;
    cpuPkg::dePayloadT               deIn, deQ;
    cpuPkg::emPayloadT               emIn, emQ;
    cpuPkg::mwPayloadT               mwIn, mwQ;
    cpuPkg::ctrlT                    ctrlD;
    logic [cpuPkg::RegAddrWidth-1:0] rsD, rtD, destD;
    logic [cpuPkg::DataWidth-1:0]    immD, rsValD, rtValD;
    logic [cpuPkg::DataWidth-1:0]    memResult;
    logic                            branchTaken;
    logic [cpuPkg::DataWidth-1:0]    branchTarget;
    logic                            stallF, stallD, flushD, flushE;
    logic [1:0]                      fwdA, fwdB;

    // fetch
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc <= cpuPkg::ResetPc;
        end else if (branchTaken) begin
            pc <= branchTarget; // resolved in execute
        end else if (!stallF) begin
            pc <= pc + 32'd4;
        end
    end

    assign pcAligned  = (pc[1:0] == 2'b00);
    assign instAddr_o = pc;
    assign instEn_o   = pcAligned & ~stallF;
    assign fdIn.pc    = pc;
    assign fdIn.instr = pcAligned ? instr_i : '0; // misaligned fetch becomes nop

    stageReg #(.payloadT(cpuPkg::fdPayloadT)) u_fdReg (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (stallD),
        .flush_i (flushD),
        .d_i     (fdIn),
        .q_o     (fdQ)
    );

    // decode
    mainDecoder u_mainDecoder (
        .instr_i (fdQ.instr),
        .ctrl_o  (ctrlD),
        .rs_o    (rsD),
        .rt_o    (rtD),
        .dest_o  (destD),
        .imm_o   (immD)
    );

    regFile u_regFile (
        .clk      (clk),
        .rst_i    (rst_i),
        .we_i     (mwQ.regWrite),
        .waddr_i  (mwQ.dest),
        .wdata_i  (mwQ.result),
        .raddr1_i (rsD),
        .raddr2_i (rtD),
        .rdata1_o (rsValD),
        .rdata2_o (rtValD)
    );

    assign deIn.pc    = fdQ.pc;
    assign deIn.ctrl  = ctrlD;
    assign deIn.rs    = rsD;
    assign deIn.rt    = rtD;
    assign deIn.dest  = destD;
    assign deIn.rsVal = rsValD;
    assign deIn.rtVal = rtValD;
    assign deIn.imm   = immD;

    stageReg #(.payloadT(cpuPkg::dePayloadT)) u_deReg (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (1'b0),
        .flush_i (flushE),
        .d_i     (deIn),
        .q_o     (deQ)
    );

    // execute
    executeUnit u_executeUnit (
        .de_i           (deQ),
        .fwdA_i         (fwdA),
        .fwdB_i         (fwdB),
        .memResult_i    (memResult),
        .wbResult_i     (mwQ.result),
        .em_o           (emIn),
        .branchTaken_o  (branchTaken),
        .branchTarget_o (branchTarget)
    );

    stageReg #(.payloadT(cpuPkg::emPayloadT)) u_emReg (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (emIn),
        .q_o     (emQ)
    );

    // memory
    assign memEn_o    = emQ.memRead | emQ.memWrite;
    assign memAddr_o  = emQ.aluResult;
    assign memWen_o   = {4{emQ.memWrite}}; // word stores only
    assign memWdata_o = emQ.storeData;
    assign memResult  = emQ.memRead ? memRdata_i : emQ.aluResult;

    assign mwIn.pc       = emQ.pc;
    assign mwIn.regWrite = emQ.regWrite;
    assign mwIn.dest     = emQ.dest;
    assign mwIn.result   = memResult;

    stageReg #(.payloadT(cpuPkg::mwPayloadT)) u_mwReg (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (mwIn),
        .q_o     (mwQ)
    );

    // writeback trace, $zero writes hidden
    assign debugWbPc_o      = mwQ.pc;
    assign debugWbRfWen_o   = {4{mwQ.regWrite && (mwQ.dest != '0)}};
    assign debugWbRfWnum_o  = mwQ.dest;
    assign debugWbRfWdata_o = mwQ.result;

    hazardUnit u_hazardUnit (
        .rsD_i         (rsD),
        .rtD_i         (rtD),
        .rsE_i         (deQ.rs),
        .rtE_i         (deQ.rt),
        .destE_i       (deQ.dest),
        .memReadE_i    (deQ.ctrl.memRead),
        .branchTaken_i (branchTaken),
        .regWriteM_i   (emQ.regWrite),
        .destM_i       (emQ.dest),
        .regWriteW_i   (mwQ.regWrite),
        .destW_i       (mwQ.dest),
        .stallF_o      (stallF),
        .stallD_o      (stallD),
        .flushD_o      (flushD),
        .flushE_o      (flushE),
        .fwdA_o        (fwdA),
        .fwdB_o        (fwdB)
    );

endmodule

//--- design/hazardUnit.sv
module hazardUnit (
    input  logic [cpuPkg::RegAddrWidth-1:0] rsD_i,
    input  logic [cpuPkg::RegAddrWidth-1:0] rtD_i,
    input  logic [cpuPkg::RegAddrWidth-1:0] rsE_i,
    input  logic [cpuPkg::RegAddrWidth-1:0] rtE_i,
    input  logic [cpuPkg::RegAddrWidth-1:0] destE_i,
    input  logic                            memReadE_i,
    input  logic                            branchTaken_i,
    input  logic                            regWriteM_i,
    input  logic [cpuPkg::RegAddrWidth-1:0] destM_i,
    input  logic                            regWriteW_i,
    input  logic [cpuPkg::RegAddrWidth-1:0] destW_i,
    output logic                            stallF_o,
    output logic                            stallD_o,
    output logic                            flushD_o,
    output logic                            flushE_o,
    output logic [1:0]                      fwdA_o,
    output logic [1:0]                      fwdB_o
);

    logic loadUse;

    // youngest producer wins
    function automatic logic [1:0] fwdSel(input logic [cpuPkg::RegAddrWidth-1:0] src);
        if (src == '0) begin
            return 2'b00;
        end else if (regWriteM_i && destM_i == src) begin
            return 2'b01;
        end else if (regWriteW_i && destW_i == src) begin
            return 2'b10;
        end
        return 2'b00;
    endfunction

    always_comb begin
        fwdA_o = fwdSel(rsE_i);
        fwdB_o = fwdSel(rtE_i);
    end

    // load data only exists in the memory stage
    assign loadUse = memReadE_i && (destE_i != '0) &&
                     (destE_i == rsD_i || destE_i == rtD_i);

    assign stallF_o = loadUse & ~branchTaken_i; // redirect overrides stall
    assign stallD_o = loadUse & ~branchTaken_i;
    assign flushD_o = branchTaken_i;
    assign flushE_o = branchTaken_i | loadUse; // bubble into execute

endmodule

//--- design/executeUnit.sv
module executeUnit (
    input  cpuPkg::dePayloadT            de_i,
    input  logic [1:0]                   fwdA_i,
    input  logic [1:0]                   fwdB_i,
    input  logic [cpuPkg::DataWidth-1:0] memResult_i,
    input  logic [cpuPkg::DataWidth-1:0] wbResult_i,
    output cpuPkg::emPayloadT            em_o,
    output logic                         branchTaken_o,
    output logic [cpuPkg::DataWidth-1:0] branchTarget_o
);

    logic [cpuPkg::DataWidth-1:0] srcA;
    logic [cpuPkg::DataWidth-1:0] rtFwd;
    logic [cpuPkg::DataWidth-1:0] srcB;
    logic [cpuPkg::DataWidth-1:0] aluOut;

    // 01 from memory stage, 10 from writeback
    function automatic logic [cpuPkg::DataWidth-1:0] pickOperand(
        input logic [1:0]                   sel,
        input logic [cpuPkg::DataWidth-1:0] regVal,
        input logic [cpuPkg::DataWidth-1:0] memVal,
        input logic [cpuPkg::DataWidth-1:0] wbVal
    );
        unique case (sel)
            2'b01:   return memVal;
            2'b10:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA  = pickOperand(fwdA_i, de_i.rsVal, memResult_i, wbResult_i);
    assign rtFwd = pickOperand(fwdB_i, de_i.rtVal, memResult_i, wbResult_i);
    assign srcB  = de_i.ctrl.useImm ? de_i.imm : rtFwd;

    always_comb begin
        unique case (de_i.ctrl.aluOp)
            cpuPkg::AluAdd: aluOut = srcA + srcB;
            cpuPkg::AluSub: aluOut = srcA - srcB;
            cpuPkg::AluAnd: aluOut = srcA & srcB;
            cpuPkg::AluOr:  aluOut = srcA | srcB;
            cpuPkg::AluSlt: aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
            cpuPkg::AluLui: aluOut = {srcB[15:0], 16'b0};
            default:        aluOut = '0;
        endcase
    end

    // compare uses forwarded rs/rt, never the immediate
    assign branchTaken_o  = de_i.ctrl.branch & ((srcA == rtFwd) ^ de_i.ctrl.branchNe);
    assign branchTarget_o = de_i.pc + 32'd4 + {de_i.imm[29:0], 2'b00};

    assign em_o.pc        = de_i.pc;
    assign em_o.regWrite  = de_i.ctrl.regWrite;
    assign em_o.memRead   = de_i.ctrl.memRead;
    assign em_o.memWrite  = de_i.ctrl.memWrite;
    assign em_o.dest      = de_i.dest;
    assign em_o.aluResult = aluOut;
    assign em_o.storeData = rtFwd; // sw data after forwarding

endmodule

//--- design/stageReg.sv
module stageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rst_i,
    input  logic    stall_i,
    input  logic    flush_i,
    input  payloadT d_i,
    output payloadT q_o
);

    // an all-zero payload is a bubble
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            q_o <= '0; // flush beats stall
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- design/regFile.sv
module regFile (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            we_i,
    input  logic [cpuPkg::RegAddrWidth-1:0] waddr_i,
    input  logic [cpuPkg::DataWidth-1:0]    wdata_i,
    input  logic [cpuPkg::RegAddrWidth-1:0] raddr1_i,
    input  logic [cpuPkg::RegAddrWidth-1:0] raddr2_i,
    output logic [cpuPkg::DataWidth-1:0]    rdata1_o,
    output logic [cpuPkg::DataWidth-1:0]    rdata2_o
);

    logic [cpuPkg::DataWidth-1:0] regs [32];
    logic                         wrValid;

    assign wrValid = we_i && (waddr_i != '0); // $zero stays zero

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrValid) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback value seen by decode in the same cycle
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (wrValid && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (wrValid && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

//--- design/mainDecoder.sv
module mainDecoder (
    input  logic [cpuPkg::DataWidth-1:0]    instr_i,
    output cpuPkg::ctrlT                    ctrl_o,
    output logic [cpuPkg::RegAddrWidth-1:0] rs_o,
    output logic [cpuPkg::RegAddrWidth-1:0] rt_o,
    output logic [cpuPkg::RegAddrWidth-1:0] dest_o,
    output logic [cpuPkg::DataWidth-1:0]    imm_o
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];
    assign rs_o   = instr_i[25:21];
    assign rt_o   = instr_i[20:16];

    always_comb begin
        ctrl_o = '0; // anything unknown retires as a nop
        unique case (opcode)
            cpuPkg::OpRtype: begin
                ctrl_o.regWrite = 1'b1;
                unique case (funct)
                    cpuPkg::FnAddu: ctrl_o.aluOp = cpuPkg::AluAdd;
                    cpuPkg::FnSubu: ctrl_o.aluOp = cpuPkg::AluSub;
                    cpuPkg::FnAnd:  ctrl_o.aluOp = cpuPkg::AluAnd;
                    cpuPkg::FnOr:   ctrl_o.aluOp = cpuPkg::AluOr;
                    cpuPkg::FnSlt:  ctrl_o.aluOp = cpuPkg::AluSlt;
                    default:        ctrl_o = '0;
                endcase
            end
            cpuPkg::OpAddiu: begin
                ctrl_o.aluOp    = cpuPkg::AluAdd;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.destIsRt = 1'b1;
                ctrl_o.signExt  = 1'b1;
            end
            cpuPkg::OpOri: begin
                ctrl_o.aluOp    = cpuPkg::AluOr;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.destIsRt = 1'b1; // zero extended
            end
            cpuPkg::OpLui: begin
                ctrl_o.aluOp    = cpuPkg::AluLui;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.destIsRt = 1'b1;
            end
            cpuPkg::OpLw: begin
                ctrl_o.aluOp    = cpuPkg::AluAdd; // base + offset
                ctrl_o.useImm   = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.memRead  = 1'b1;
                ctrl_o.destIsRt = 1'b1;
                ctrl_o.signExt  = 1'b1;
            end
            cpuPkg::OpSw: begin
                ctrl_o.aluOp    = cpuPkg::AluAdd;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.memWrite = 1'b1;
                ctrl_o.signExt  = 1'b1;
            end
            cpuPkg::OpBeq: begin
                ctrl_o.aluOp   = cpuPkg::AluSub;
                ctrl_o.branch  = 1'b1;
                ctrl_o.signExt = 1'b1;
            end
            cpuPkg::OpBne: begin
                ctrl_o.aluOp    = cpuPkg::AluSub;
                ctrl_o.branch   = 1'b1;
                ctrl_o.branchNe = 1'b1;
                ctrl_o.signExt  = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

    assign dest_o = ctrl_o.destIsRt ? instr_i[20:16] : instr_i[15:11];
    assign imm_o  = {{16{ctrl_o.signExt & instr_i[15]}}, instr_i[15:0]};

endmodule

//--- design/cpuPkg.sv
package cpuPkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam logic [DataWidth-1:0] ResetPc = 32'hbfc0_0000; // boot vector

    // primary opcodes
    localparam logic [5:0] OpRtype = 6'h00;
    localparam logic [5:0] OpAddiu = 6'h09;
    localparam logic [5:0] OpOri   = 6'h0d;
    localparam logic [5:0] OpLui   = 6'h0f;
    localparam logic [5:0] OpLw    = 6'h23;
    localparam logic [5:0] OpSw    = 6'h2b;
    localparam logic [5:0] OpBeq   = 6'h04;
    localparam logic [5:0] OpBne   = 6'h05;

    // function codes for OpRtype
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnSlt  = 6'h2a;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt,
        AluLui // immediate into upper half
    } aluOpT;

    typedef struct packed {
        aluOpT aluOp;
        logic  useImm;   // alu b from immediate
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branch;
        logic  branchNe; // bne instead of beq
        logic  destIsRt; // i-type destination
        logic  signExt;
    } ctrlT;

    typedef struct packed {
        logic [DataWidth-1:0] pc;
        logic [DataWidth-1:0] instr;
    } fdPayloadT;

    typedef struct packed {
        logic [DataWidth-1:0]    pc;
        ctrlT                    ctrl;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [RegAddrWidth-1:0] dest;
        logic [DataWidth-1:0]    rsVal;
        logic [DataWidth-1:0]    rtVal;
        logic [DataWidth-1:0]    imm;
    } dePayloadT;

    typedef struct packed {
        logic [DataWidth-1:0]    pc;
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
        logic [RegAddrWidth-1:0] dest;
        logic [DataWidth-1:0]    aluResult; // also the memory address
        logic [DataWidth-1:0]    storeData;
    } emPayloadT;

    typedef struct packed {
        logic [DataWidth-1:0]    pc;
        logic                    regWrite;
        logic [RegAddrWidth-1:0] dest;
        logic [DataWidth-1:0]    result;
    } mwPayloadT;

endpackage
